// File: design/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int RAM_WORDS   = 1024;                // 4 KiB
  localparam int RAM_IDX_W   = $clog2(RAM_WORDS);
  localparam int N_MGR       = 2;
  localparam int N_TGT       = 3;
  localparam int MGR_INSTR   = 0;
  localparam int MGR_DATA    = 1;

  localparam logic [ADDR_W-1:0] REGION_MASK   = 32'hF000_0000;  // top nibble picks target
  localparam logic [ADDR_W-1:0] RAM_BASE      = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE     = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] EXIT_BASE     = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] UART_DATA_OFS = 32'h0000_0000;  // tx data
  localparam logic [ADDR_W-1:0] UART_STAT_OFS = 32'h0000_0004;  // bit 0 busy

  localparam int CLKS_PER_BIT = 4;
  localparam int BAUD_W       = $clog2(CLKS_PER_BIT);
  localparam int FRAME_BITS   = 10;                 // start + 8 data + stop
  localparam int FRAME_CNT_W  = $clog2(FRAME_BITS);

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_DECERR = 2'd3;

  // values double as target port index on the crossbar
  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_UART = 2'd1,
    TGT_EXIT = 2'd2,
    TGT_NONE = 2'd3
  } target_e;

  typedef struct packed {
    logic              wr_valid;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;
    logic              rd_valid;
    logic [ADDR_W-1:0] rd_addr;
    logic              b_ready;
    logic              r_ready;
  } axil_req_t;

  typedef struct packed {
    logic              wr_ready;
    logic              b_valid;
    logic [1:0]        b_resp;
    logic              rd_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic [1:0]        r_resp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// File: design/axil_xbar.sv
`timescale 1ns/100ps
`default_nettype none

module axil_xbar
  import mem_sys_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t mgr_req_i [N_MGR],
  output axil_rsp_t mgr_rsp_o [N_MGR],
  output axil_req_t tgt_req_o [N_TGT],
  input  axil_rsp_t tgt_rsp_i [N_TGT]
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GRANT,
    ST_RESP
  } state_e;

  state_e    state_q;
  logic      last_q;      // manager served last
  logic      mgr_q;       // granted manager
  logic      is_wr_q;     // granted op is a write
  target_e   tgt_q;       // decoded target, latched

  logic [N_MGR-1:0] req_any;
  logic             pick;
  logic             sel_wr;
  logic [ADDR_W-1:0] sel_addr;
  logic             in_grant;
  logic             in_resp;
  logic             req_fire;
  logic             rsp_fire;
  axil_req_t        cur_req;
  axil_req_t        fwd_req;
  axil_rsp_t        local_rsp;
  axil_rsp_t        cur_rsp;
  axil_rsp_t        out_rsp;

  function automatic target_e decode(input logic [ADDR_W-1:0] addr);
    case (addr & REGION_MASK)
      RAM_BASE:  decode = TGT_RAM;
      UART_BASE: decode = TGT_UART;
      EXIT_BASE: decode = TGT_EXIT;
      default:   decode = TGT_NONE;
    endcase
  endfunction

  // arbitration, evaluated only while idle
  always_comb begin
    for (int m = 0; m < N_MGR; m++) begin
      req_any[m] = mgr_req_i[m].wr_valid | mgr_req_i[m].rd_valid;
    end
    if (&req_any) begin
      pick = ~last_q;                   // round robin on contention
    end else begin
      pick = req_any[1];
    end
    sel_wr   = mgr_req_i[pick].wr_valid;  // write wins within a manager
    sel_addr = sel_wr ? mgr_req_i[pick].wr_addr : mgr_req_i[pick].rd_addr;
  end

  assign in_grant = (state_q == ST_GRANT);
  assign in_resp  = (state_q == ST_RESP);

  // decode errors are answered here, one cycle after acceptance
  always_comb begin
    local_rsp          = '0;
    local_rsp.wr_ready = 1'b1;
    local_rsp.rd_ready = 1'b1;
    local_rsp.b_valid  = 1'b1;
    local_rsp.r_valid  = 1'b1;
    local_rsp.b_resp   = RESP_DECERR;
    local_rsp.r_resp   = RESP_DECERR;
  end

  always_comb begin
    cur_req          = mgr_req_i[mgr_q];
    fwd_req          = cur_req;
    fwd_req.wr_addr  = cur_req.wr_addr & ~REGION_MASK;  // target sees its offset
    fwd_req.rd_addr  = cur_req.rd_addr & ~REGION_MASK;
    fwd_req.wr_valid = cur_req.wr_valid & in_grant & is_wr_q;
    fwd_req.rd_valid = cur_req.rd_valid & in_grant & ~is_wr_q;
    fwd_req.b_ready  = cur_req.b_ready & in_resp;
    fwd_req.r_ready  = cur_req.r_ready & in_resp;

    if (tgt_q == TGT_NONE) begin
      cur_rsp = local_rsp;
    end else begin
      cur_rsp = tgt_rsp_i[tgt_q];
    end
    out_rsp          = cur_rsp;
    out_rsp.wr_ready = cur_rsp.wr_ready & in_grant & is_wr_q;
    out_rsp.rd_ready = cur_rsp.rd_ready & in_grant & ~is_wr_q;
    out_rsp.b_valid  = cur_rsp.b_valid & in_resp & is_wr_q;
    out_rsp.r_valid  = cur_rsp.r_valid & in_resp & ~is_wr_q;

    req_fire = (out_rsp.wr_ready & cur_req.wr_valid) | (out_rsp.rd_ready & cur_req.rd_valid);
    rsp_fire = (out_rsp.b_valid & cur_req.b_ready) | (out_rsp.r_valid & cur_req.r_ready);

    for (int t = 0; t < N_TGT; t++) begin
      tgt_req_o[t] = (state_q != ST_IDLE && tgt_q == target_e'(t)) ? fwd_req : '0;
    end
    for (int m = 0; m < N_MGR; m++) begin
      mgr_rsp_o[m] = (state_q != ST_IDLE && mgr_q == 1'(m)) ? out_rsp : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      last_q  <= 1'b1;    // instr port goes first
      mgr_q   <= 1'b0;
      is_wr_q <= 1'b0;
      tgt_q   <= TGT_NONE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (|req_any) begin
            state_q <= ST_GRANT;
            mgr_q   <= pick;
            is_wr_q <= sel_wr;
            tgt_q   <= decode(sel_addr);
          end
        end
        ST_GRANT: begin
          if (req_fire) begin
            state_q <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (rsp_fire) begin
            state_q <= ST_IDLE;
            last_q  <= mgr_q;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/axil_ram.sv
`timescale 1ns/100ps
`default_nettype none

module axil_ram
  import mem_sys_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o
);

  logic [DATA_W-1:0]    mem_q [RAM_WORDS];
  logic [DATA_W-1:0]    r_data_q;
  logic                 b_valid_q;
  logic                 r_valid_q;
  logic                 pending;
  logic                 wr_fire;
  logic                 rd_fire;
  logic [RAM_IDX_W-1:0] wr_idx;
  logic [RAM_IDX_W-1:0] rd_idx;

  assign pending = b_valid_q | r_valid_q;               // one response in flight
  assign wr_fire = req_i.wr_valid & ~pending;
  assign rd_fire = req_i.rd_valid & ~pending & ~req_i.wr_valid;
  assign wr_idx  = req_i.wr_addr[RAM_IDX_W+1:2];        // word offset
  assign rd_idx  = req_i.rd_addr[RAM_IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.wr_strb[b]) begin
          mem_q[wr_idx][8*b +: 8] <= req_i.wr_data[8*b +: 8];
        end
      end
    end
    if (rd_fire) begin
      r_data_q <= mem_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_valid_q <= 1'b0;                              // held until taken
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rsp_o          = '0;
    rsp_o.wr_ready = ~pending;
    rsp_o.rd_ready = ~pending & ~req_i.wr_valid;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = RESP_OKAY;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = RESP_OKAY;
  end

endmodule

`default_nettype wire

// File: design/axil_uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module axil_uart_tx
  import mem_sys_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o,
  output logic      tx_o
);

  logic [FRAME_BITS-1:0]  shift_q;
  logic [BAUD_W-1:0]      baud_q;
  logic [FRAME_CNT_W-1:0] bit_q;
  logic                   busy_q;
  logic                   b_valid_q;
  logic                   r_valid_q;
  logic [DATA_W-1:0]      r_data_q;
  logic                   pending;
  logic                   is_data_wr;
  logic                   is_stat_rd;
  logic                   wr_ready;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   bit_end;

  assign pending    = b_valid_q | r_valid_q;
  assign is_data_wr = (req_i.wr_addr == UART_DATA_OFS);
  assign is_stat_rd = (req_i.rd_addr == UART_STAT_OFS);
  assign wr_ready   = ~pending & ~(busy_q & is_data_wr);  // stall data writes mid-frame
  assign wr_fire    = req_i.wr_valid & wr_ready;
  assign rd_fire    = req_i.rd_valid & ~pending & ~req_i.wr_valid;
  assign bit_end    = (baud_q == BAUD_W'(CLKS_PER_BIT - 1));
  assign tx_o       = busy_q ? shift_q[0] : 1'b1;        // line idles high

  // serializer, lsb first
  always_ff @(posedge clk_i) begin
    if (wr_fire && is_data_wr) begin
      shift_q <= {1'b1, req_i.wr_data[7:0], 1'b0};
    end else if (busy_q && bit_end) begin
      shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      baud_q <= '0;
      bit_q  <= '0;
    end else if (wr_fire && is_data_wr) begin
      busy_q <= 1'b1;
      baud_q <= '0;
      bit_q  <= '0;
    end else if (busy_q) begin
      baud_q <= bit_end ? '0 : baud_q + 1'b1;
      if (bit_end) begin
        bit_q <= bit_q + 1'b1;
        if (bit_q == FRAME_CNT_W'(FRAME_BITS - 1)) begin
          busy_q <= 1'b0;                                 // stop bit done
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= is_stat_rd ? {{(DATA_W-1){1'b0}}, busy_q} : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      b_valid_q <= wr_fire | (b_valid_q & ~req_i.b_ready);
      r_valid_q <= rd_fire | (r_valid_q & ~req_i.r_ready);
    end
  end

  always_comb begin
    rsp_o          = '0;
    rsp_o.wr_ready = wr_ready;
    rsp_o.rd_ready = ~pending & ~req_i.wr_valid;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = RESP_OKAY;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = r_data_q;
    rsp_o.r_resp   = RESP_OKAY;
  end

endmodule

`default_nettype wire

// File: design/axil_exit_dec.sv
`timescale 1ns/100ps
`default_nettype none

module axil_exit_dec
  import mem_sys_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o,
  output logic      exit_valid_o,
  output logic      exit_zero_o
);

  logic              exit_valid_q;
  logic              exit_zero_q;
  logic [DATA_W-1:0] value_q;
  logic              b_valid_q;
  logic              r_valid_q;
  logic              pending;
  logic              wr_fire;
  logic              rd_fire;

  assign pending = b_valid_q | r_valid_q;
  assign wr_fire = req_i.wr_valid & ~pending;
  assign rd_fire = req_i.rd_valid & ~pending & ~req_i.wr_valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_q <= 1'b0;
      exit_zero_q  <= 1'b0;
      value_q      <= '0;
      b_valid_q    <= 1'b0;
      r_valid_q    <= 1'b0;
    end else begin
      if (wr_fire && !exit_valid_q) begin      // first exit code sticks
        exit_valid_q <= 1'b1;
        exit_zero_q  <= (req_i.wr_data == '0);  // zero means pass
        value_q      <= req_i.wr_data;
      end
      b_valid_q <= wr_fire | (b_valid_q & ~req_i.b_ready);
      r_valid_q <= rd_fire | (r_valid_q & ~req_i.r_ready);
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_zero_o  = exit_zero_q;

  always_comb begin
    rsp_o          = '0;
    rsp_o.wr_ready = ~pending;
    rsp_o.rd_ready = ~pending & ~req_i.wr_valid;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.b_resp   = RESP_OKAY;
    rsp_o.r_valid  = r_valid_q;
    rsp_o.r_data   = value_q;
    rsp_o.r_resp   = RESP_OKAY;
  end

endmodule

`default_nettype wire

// File: design/mem_sys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sys_top
  import mem_sys_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t instr_req_i,
  output axil_rsp_t instr_rsp_o,
  input  axil_req_t data_req_i,
  output axil_rsp_t data_rsp_o,
  output logic      exit_valid_o,
  output logic      exit_zero_o,
  output logic      tx_o
);

  axil_req_t mgr_req [N_MGR];
  axil_rsp_t mgr_rsp [N_MGR];
  axil_req_t tgt_req [N_TGT];
  axil_rsp_t tgt_rsp [N_TGT];

  assign mgr_req[MGR_INSTR] = instr_req_i;  // fetch side
  assign mgr_req[MGR_DATA]  = data_req_i;   // load/store side
  assign instr_rsp_o        = mgr_rsp[MGR_INSTR];
  assign data_rsp_o         = mgr_rsp[MGR_DATA];

  axil_xbar xbar0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .mgr_req_i (mgr_req),
    .mgr_rsp_o (mgr_rsp),
    .tgt_req_o (tgt_req),
    .tgt_rsp_i (tgt_rsp)
  );

  axil_ram ram0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (tgt_req[TGT_RAM]),
    .rsp_o   (tgt_rsp[TGT_RAM])
  );

  axil_uart_tx uart0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (tgt_req[TGT_UART]),
    .rsp_o   (tgt_rsp[TGT_UART]),
    .tx_o    (tx_o)
  );

  axil_exit_dec exit0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (tgt_req[TGT_EXIT]),
    .rsp_o        (tgt_rsp[TGT_EXIT]),
    .exit_valid_o (exit_valid_o),
    .exit_zero_o  (exit_zero_o)
  );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DLY    = 10;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #DRIVE_DLY;
    reset_o = 1'b0;         // released just after the edge
  end

endmodule

`default_nettype wire

// File: test/tb_mem_sys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_sys
  import mem_sys_pkg::*;
();

  localparam int PERIOD_NS   = 100;
  localparam int DRIVE_DLY   = 10;
  localparam int BIT_NS      = CLKS_PER_BIT * PERIOD_NS;
  localparam int STEP_CYCLES = 200;                 // cycle budget per table entry
  localparam logic [ADDR_W-1:0] TX_ADDR   = UART_BASE + UART_DATA_OFS;
  localparam logic [ADDR_W-1:0] STAT_ADDR = UART_BASE + UART_STAT_OFS;
  localparam logic [ADDR_W-1:0] BAD_ADDR  = 32'h3000_0000;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_BOTH                                         // data writes addr, instr reads addr+4
  } op_e;

  typedef struct packed {
    logic              port;
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] exp_data;                    // used for non-ram reads
    logic [1:0]        exp_resp;
  } step_t;

  logic              clk;
  logic              reset;
  axil_req_t         req_q [N_MGR];
  axil_rsp_t         instr_rsp;
  axil_rsp_t         data_rsp;
  logic              exit_valid;
  logic              exit_zero;
  logic              tx;
  step_t             steps [$];
  logic [DATA_W-1:0] model [RAM_WORDS];             // expected ram contents
  logic [7:0]        tx_exp [$];
  int                tx_count;
  int                frames_done;
  int                frames_planned;
  bit                table_ready;
  bit                exit_seen;

  tb_clock_gen clkgen0 (
    .clk_o   (clk),
    .reset_o (reset)
  );

  mem_sys_top dut0 (
    .clk_i        (clk),
    .reset_i      (reset),
    .instr_req_i  (req_q[MGR_INSTR]),
    .instr_rsp_o  (instr_rsp),
    .data_req_i   (req_q[MGR_DATA]),
    .data_rsp_o   (data_rsp),
    .exit_valid_o (exit_valid),
    .exit_zero_o  (exit_zero),
    .tx_o         (tx)
  );

  function automatic step_t make_step(input logic port, input op_e op,
                                      input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data,
                                      input logic [STRB_W-1:0] strb,
                                      input logic [DATA_W-1:0] exp_data,
                                      input logic [1:0] exp_resp);
    make_step = {port, op, addr, data, strb, exp_data, exp_resp};
  endfunction

  function automatic axil_rsp_t rsp_of(input logic port);
    rsp_of = (port == MGR_DATA) ? data_rsp : instr_rsp;
  endfunction

  function automatic logic is_ram(input logic [ADDR_W-1:0] addr);
    is_ram = ((addr & REGION_MASK) == RAM_BASE);
  endfunction

  function automatic logic [RAM_IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] addr);
    word_idx = addr[RAM_IDX_W+1:2];
  endfunction

  function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data,
                                      input logic [STRB_W-1:0] strb);
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        model[word_idx(addr)][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic check(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("FAIL %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic write_txn(input logic port, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                           output logic [1:0] resp);
    axil_rsp_t r;
    req_q[port].wr_addr  = addr;
    req_q[port].wr_data  = data;
    req_q[port].wr_strb  = strb;
    req_q[port].wr_valid = 1'b1;
    req_q[port].b_ready  = 1'b1;
    do begin
      @(negedge clk);
      r = rsp_of(port);
    end while (!r.wr_ready);                        // transfers on the next edge
    @(posedge clk);
    #DRIVE_DLY;
    req_q[port].wr_valid = 1'b0;
    do begin
      @(negedge clk);
      r = rsp_of(port);
    end while (!r.b_valid);
    resp = r.b_resp;
    @(posedge clk);
    #DRIVE_DLY;
    req_q[port].b_ready = 1'b0;
  endtask

  task automatic read_txn(input logic port, input logic [ADDR_W-1:0] addr,
                          output logic [DATA_W-1:0] data, output logic [1:0] resp);
    axil_rsp_t r;
    req_q[port].rd_addr  = addr;
    req_q[port].rd_valid = 1'b1;
    req_q[port].r_ready  = 1'b1;
    do begin
      @(negedge clk);
      r = rsp_of(port);
    end while (!r.rd_ready);
    @(posedge clk);
    #DRIVE_DLY;
    req_q[port].rd_valid = 1'b0;
    do begin
      @(negedge clk);
      r = rsp_of(port);
    end while (!r.r_valid);
    data = r.r_data;
    resp = r.r_resp;
    @(posedge clk);
    #DRIVE_DLY;
    req_q[port].r_ready = 1'b0;
  endtask

  task automatic build_table();
    steps.push_back(make_step(MGR_DATA,  OP_WR,   32'h10,  $urandom, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_RD,   32'h10,  '0,       4'h0, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   32'h10,  $urandom, 4'h3, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_RD,   32'h10,  '0,       4'h0, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   32'hFFC, $urandom, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   32'hFFC, $urandom, 4'h4, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_RD,   32'hFFC, '0,       4'h0, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   32'h20,  $urandom, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   32'h24,  $urandom, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   32'h28,  $urandom, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_INSTR, OP_RD,   32'h24,  '0,       4'h0, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_INSTR, OP_RD,   32'hFFC, '0,       4'h0, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_BOTH, 32'h20,  $urandom, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_BOTH, 32'h24,  $urandom, 4'h6, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_INSTR, OP_RD,   32'h20,  '0,       4'h0, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   BAD_ADDR, $urandom, 4'hF, '0, RESP_DECERR));
    steps.push_back(make_step(MGR_DATA,  OP_RD,   BAD_ADDR, '0,      4'h0, '0, RESP_DECERR));
    steps.push_back(make_step(MGR_INSTR, OP_RD,   BAD_ADDR + 32'h40, '0, 4'h0, '0, RESP_DECERR));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   TX_ADDR,   32'h5A, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_RD,   STAT_ADDR, '0,     4'h0, 32'd1, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   TX_ADDR,   32'hC3, 4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_RD,   STAT_ADDR, '0,     4'h0, 32'd1, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_WR,   EXIT_BASE, '0,     4'hF, '0, RESP_OKAY));
    steps.push_back(make_step(MGR_DATA,  OP_RD,   EXIT_BASE, '0,     4'h0, '0, RESP_OKAY));
    foreach (steps[i]) begin
      if (steps[i].op == OP_WR && steps[i].addr == TX_ADDR) begin
        frames_planned++;
      end
    end
  endtask

  task automatic run_step(input step_t s);
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] exp;
    logic [1:0]        wresp;
    logic [1:0]        rresp;
    int                prior;
    if (!exit_seen) begin
      check(exit_valid, 1'b0, "exit_valid_o high before exit write");
    end
    case (s.op)
      OP_WR: begin
        prior = tx_count;
        if (s.addr == TX_ADDR) begin
          tx_exp.push_back(s.data[7:0]);
          tx_count++;
        end
        write_txn(s.port, s.addr, s.data, s.strb, wresp);
        check(wresp, s.exp_resp, "write response");
        if (s.addr == TX_ADDR) begin
          check(frames_done, prior, "tx write done before previous frame ended");
        end
        if (is_ram(s.addr)) begin
          model_write(s.addr, s.data, s.strb);
        end
        if (s.addr == EXIT_BASE) begin
          check(exit_valid, 1'b1, "exit_valid_o after exit write");
          check(exit_zero, s.data == '0, "exit_zero_o after exit write");
          exit_seen = 1'b1;
        end
      end
      OP_RD: begin
        exp = is_ram(s.addr) ? model[word_idx(s.addr)] : s.exp_data;
        read_txn(s.port, s.addr, rdata, rresp);
        check(rdata, exp, "read data");
        check(rresp, s.exp_resp, "read response");
      end
      default: begin
        exp = model[word_idx(s.addr + 4)];
        fork
          write_txn(MGR_DATA, s.addr, s.data, s.strb, wresp);
          read_txn(MGR_INSTR, s.addr + 4, rdata, rresp);
        join
        check(wresp, s.exp_resp, "data port write response, both ports");
        check(rdata, exp, "instr port read data, both ports");
        check(rresp, s.exp_resp, "instr port read response, both ports");
        model_write(s.addr, s.data, s.strb);
      end
    endcase
  endtask

  // samples each bit at its centre after the falling start edge
  initial begin : uart_monitor
    logic [7:0] rx_byte;
    @(negedge reset);
    forever begin
      @(negedge tx);
      #(BIT_NS / 2);
      check(tx, 1'b0, "uart start bit");
      for (int i = 0; i < 8; i++) begin
        #(BIT_NS);
        rx_byte[i] = tx;
      end
      #(BIT_NS);
      check(tx, 1'b1, "uart stop bit");
      check(tx_exp.size() > 0, 1'b1, "uart frame without a tx write");
      check(rx_byte, tx_exp.pop_front(), "uart byte");
      frames_done++;
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = steps.size() * STEP_CYCLES + frames_planned * FRAME_BITS * CLKS_PER_BIT + 20;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, bus transactions or uart frames never finished", limit);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    req_q[MGR_INSTR] = '0;
    req_q[MGR_DATA]  = '0;
    tx_count         = 0;
    frames_done      = 0;
    frames_planned   = 0;
    exit_seen        = 1'b0;
    void'($urandom(99));                            // seeded once
    build_table();
    table_ready = 1'b1;
    @(negedge reset);
    @(posedge clk);
    #DRIVE_DLY;
    check((|instr_rsp) | (|data_rsp), 1'b0, "manager response active after reset");
    check(tx, 1'b1, "tx_o idle level after reset");
    check(exit_zero, 1'b0, "exit_zero_o after reset");
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    wait (frames_done == tx_count);                 // last frame drains
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/mem_sys_pkg.sv
design/axil_xbar.sv
design/axil_ram.sv
design/axil_uart_tx.sv
design/axil_exit_dec.sv
design/mem_sys_top.sv
test/tb_clock_gen.sv
test/tb_mem_sys.sv

// File: Bender.yml
package:
  name: mem_sys

sources:
  - design/mem_sys_pkg.sv
  - design/axil_xbar.sv
  - design/axil_ram.sv
  - design/axil_uart_tx.sv
  - design/axil_exit_dec.sv
  - design/mem_sys_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_mem_sys.sv
